// ==== rtl/obj_defines.svh ====
`ifndef OBJ_DEFINES_SVH
`define OBJ_DEFINES_SVH

// Object table geometry
`define OBJ_COUNT       128
`define OBJ_WORDS       8
`define OBJ_SCRATCH_IDX 7       // Running ROM offset, kept by the scanner

// Vertical limits of the visible area
`define OBJ_LAST_LINE   223
`define OBJ_END_MARK    8'hf0   // Bottom value that closes the list

// Horizontal size, four pixels per ROM word
`define OBJ_WIDTH       16

`endif

// ==== rtl/obj_pkg.sv ====
package obj_pkg;

    // One draw request, scanner to draw engine
    typedef struct packed {
        logic [8:0]  xpos;
        logic [15:0] offset;
        logic [3:0]  bank;
        logic [1:0]  prio;
        logic [5:0]  pal;
        logic        hflip;
    } obj_cmd_t;

    // Line buffer entry, pix 0 means empty
    typedef struct packed {
        logic [1:0] prio;
        logic [5:0] pal;
        logic [3:0] pix;
    } lbuf_pxl_t;

    // Attribute word of the older board
    typedef struct packed {
        logic [1:0] rsv_hi;
        logic [5:0] pal;
        logic       rsv_mid;
        logic [2:0] bank;
        logic [1:0] rsv_lo;
        logic [1:0] prio;
    } attr_a_t;

    // Attribute word of the newer board
    typedef struct packed {
        logic [3:0] rsv;
        logic [3:0] bank;
        logic [1:0] prio;
        logic [5:0] pal;
    } attr_b_t;

    typedef union packed {
        attr_a_t attr_a;
        attr_b_t attr_b;
    } obj_attr_t;

endpackage

// ==== rtl/obj_table.sv ====
`include "obj_defines.svh"

module obj_table (
    input  logic        clk,
    input  logic        rst,
    // CPU side, Wishbone classic
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [9:0]  wb_adr,
    input  logic [15:0] wb_dat_i,
    output logic [15:0] wb_dat_o,
    output logic        wb_ack,
    // Scanner side
    input  logic [9:0]  scan_addr,
    output logic [15:0] scan_dout,
    input  logic [15:0] scan_din,
    input  logic        scan_we
);

    localparam int DEPTH = `OBJ_COUNT * `OBJ_WORDS;

    logic [15:0] mem [0:DEPTH-1];
    logic        wb_req;

    // New request only when no ack is out, so ack is a single pulse
    assign wb_req = wb_cyc & wb_stb & ~wb_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // Both ports share one array
    always_ff @(posedge clk) begin
        if (wb_req && wb_we) begin
            mem[wb_adr] <= wb_dat_i;
        end
        if (wb_req) begin
            wb_dat_o <= mem[wb_adr];  // Held through the ack cycle
        end
        if (scan_we) begin
            mem[scan_addr] <= scan_din;  // Scratch write-back
        end
        scan_dout <= mem[scan_addr];
    end

    // CPU sees each access acknowledged once
    a_ack_single: assert property (
        @(posedge clk) disable iff (rst) wb_ack |=> !wb_ack
    ) else $error("obj_table: ack held for two cycles");

endmodule

// ==== rtl/obj_scan.sv ====
`include "obj_defines.svh"

module obj_scan #(
    parameter int MODEL = 0  // 0 is the older board and 1 the newer one
) (
    input  logic              clk,
    input  logic              rst,
    // Object table
    output logic [9:0]        tbl_addr,
    input  logic [15:0]       tbl_dout,
    output logic [15:0]       tbl_din,
    output logic              tbl_we,
    // Draw commands
    output logic              start,
    input  logic              busy,
    output obj_pkg::obj_cmd_t cmd,
    // Video timing
    input  logic              flip,
    input  logic              hstart,
    input  logic [8:0]        vrender
);

    import obj_pkg::*;

    localparam int OAW = $clog2(`OBJ_COUNT);

    typedef enum logic [3:0] {
        S_IDLE, S_FETCH, S_TEST, S_XPOS, S_PITCH, S_OFFS, S_ATTR, S_SCRATCH, S_DRAW
    } state_t;

    state_t         state;
    logic [OAW-1:0] cur_obj;
    logic [2:0]     idx;
    logic [8:0]     vrf;
    logic [7:0]     top;
    logic [7:0]     bottom;
    logic           inzone;
    logic           first;
    logic [8:0]     xpos;
    logic [15:0]    pitch;
    logic [15:0]    offset;
    logic [15:0]    next_offset;
    logic [3:0]     bank;
    logic [1:0]     prio;
    logic [5:0]     pal;
    logic           hflip;
    obj_attr_t      attr;

    assign vrf    = flip ? 9'(`OBJ_LAST_LINE) - vrender : vrender;
    assign top    = tbl_dout[7:0];
    assign bottom = tbl_dout[15:8];
    // An empty or inverted zone never contains the line
    assign inzone = vrf[7:0] >= top && bottom > vrf[7:0];
    assign attr   = tbl_dout;

    // Stored offset on the first line and one pitch more on each later line
    assign next_offset = first ? offset : tbl_dout + pitch;

    assign tbl_addr = {cur_obj, idx};
    assign tbl_din  = next_offset;
    assign tbl_we   = state == S_SCRATCH;  // Address sits on the scratch word here

    always_comb begin
        cmd.xpos   = xpos;
        cmd.offset = offset;
        cmd.bank   = bank;
        cmd.prio   = prio;
        cmd.pal    = pal;
        cmd.hflip  = hflip;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            cur_obj <= '0;
            idx     <= '0;
            start   <= 1'b0;
        end else begin
            start <= 1'b0;
            if (hstart) begin
                // A new line drops whatever is left of the old list
                cur_obj <= '0;
                idx     <= '0;
                state   <= vrf <= `OBJ_LAST_LINE ? S_FETCH : S_IDLE;
            end else begin
                case (state)
                    S_FETCH: begin
                        idx   <= 3'd1;
                        state <= S_TEST;
                    end
                    S_TEST: begin
                        if (bottom >= `OBJ_END_MARK) begin
                            state <= S_IDLE;
                        end else if (!inzone) begin
                            cur_obj <= cur_obj + 1'b1;
                            idx     <= '0;
                            state   <= &cur_obj ? S_IDLE : S_FETCH;
                        end else begin
                            idx   <= 3'd2;
                            state <= S_XPOS;
                        end
                    end
                    S_XPOS: begin
                        idx   <= 3'd3;
                        state <= S_PITCH;
                    end
                    S_PITCH: begin
                        idx   <= 3'd4;
                        state <= S_OFFS;
                    end
                    S_OFFS: begin
                        idx   <= 3'(`OBJ_SCRATCH_IDX);
                        state <= S_ATTR;
                    end
                    S_ATTR: state <= S_SCRATCH;
                    S_SCRATCH: begin
                        // Next word 0 is read while the draw waits
                        cur_obj <= cur_obj + 1'b1;
                        idx     <= '0;
                        state   <= S_DRAW;
                    end
                    S_DRAW: begin
                        if (!busy) begin
                            start <= 1'b1;
                            idx   <= 3'd1;
                            // Index wrapped to 0 after object 127
                            state <= cur_obj == '0 ? S_IDLE : S_TEST;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // Object fields load one word per cycle
    always_ff @(posedge clk) begin
        case (state)
            S_TEST:  first <= top == vrf[7:0];
            S_XPOS:  xpos <= tbl_dout[8:0];
            S_PITCH: begin
                pitch <= MODEL == 1 ? {{8{tbl_dout[7]}}, tbl_dout[7:0]} : tbl_dout;
                hflip <= tbl_dout[8];
            end
            S_OFFS:  offset <= tbl_dout;
            S_ATTR: begin
                if (MODEL == 1) begin
                    bank <= attr.attr_b.bank;
                    prio <= attr.attr_b.prio;
                    pal  <= attr.attr_b.pal;
                end else begin
                    bank <= {1'b0, attr.attr_a.bank};
                    prio <= attr.attr_a.prio;
                    pal  <= attr.attr_a.pal;
                end
            end
            S_SCRATCH: offset <= next_offset;
            default: ;
        endcase
    end

    // Draw engine takes a command only when idle
    a_start_idle: assert property (
        @(posedge clk) disable iff (rst) start |-> !busy
    ) else $error("obj_scan: start raised while draw busy");

endmodule

// ==== rtl/obj_draw.sv ====
`include "obj_defines.svh"

module obj_draw (
    input  logic               clk,
    input  logic               rst,
    // Command from the scanner
    input  logic               start,
    input  obj_pkg::obj_cmd_t  cmd,
    output logic               busy,
    // Sprite ROM
    output logic               rom_cs,
    output logic [19:0]        rom_addr,
    input  logic [15:0]        rom_data,
    input  logic               rom_ok,
    // Line buffer
    output logic               buf_we,
    output logic [8:0]         buf_x,
    output obj_pkg::lbuf_pxl_t buf_pxl
);

    import obj_pkg::*;

    localparam int CW = $clog2(`OBJ_WIDTH);

    obj_cmd_t      cur;
    logic [15:0]   pxl_data;
    logic [CW-1:0] cnt;
    logic [CW-1:0] col;
    logic          drawing;
    logic          take;

    assign take = start && !busy;
    assign col  = cur.hflip ? ~cnt : cnt;  // Mirrored column counts down from 15

    assign buf_x        = cur.xpos + 9'(col);
    assign buf_pxl.prio = cur.prio;
    assign buf_pxl.pal  = cur.pal;
    assign buf_pxl.pix  = pxl_data[15:12];  // Leftmost nibble first
    assign buf_we       = drawing && pxl_data[15:12] != 4'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            rom_cs  <= 1'b0;
            drawing <= 1'b0;
            cnt     <= '0;
        end else if (take) begin
            busy   <= 1'b1;
            rom_cs <= 1'b1;
            cnt    <= '0;
        end else if (rom_cs) begin
            if (rom_ok) begin
                rom_cs  <= 1'b0;
                drawing <= 1'b1;
            end
        end else if (drawing) begin
            cnt <= cnt + 1'b1;
            if (cnt == '1) begin
                drawing <= 1'b0;
                busy    <= 1'b0;
            end else if (cnt[1:0] == 2'd3) begin
                drawing <= 1'b0;  // Word used up, fetch the next one
                rom_cs  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cur      <= cmd;
            rom_addr <= {cmd.bank, cmd.offset};
        end else if (rom_cs && rom_ok) begin
            pxl_data <= rom_data;
        end else if (drawing) begin
            pxl_data <= {pxl_data[11:0], 4'd0};
            if (cnt[1:0] == 2'd3) begin
                rom_addr[15:0] <= rom_addr[15:0] + 16'd1;  // Bank does not carry
            end
        end
    end

    a_rom_hold: assert property (
        @(posedge clk) disable iff (rst) rom_cs && !rom_ok |=> $stable(rom_addr)
    ) else $error("obj_draw: rom_addr moved during a pending fetch");

endmodule

// ==== rtl/obj_linebuf.sv ====
module obj_linebuf (
    input  logic               clk,
    input  logic               rst,
    input  logic               hstart,
    // Draw side
    input  logic               we,
    input  logic [8:0]         wr_x,
    input  obj_pkg::lbuf_pxl_t wr_pxl,
    // Video side
    input  logic [8:0]         hdump,
    output obj_pkg::lbuf_pxl_t obj_pxl
);

    import obj_pkg::*;

    lbuf_pxl_t mem [2][512];
    logic      sel;  // Bank being drawn, the other one is on screen

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel     <= 1'b0;
            obj_pxl <= '0;
        end else begin
            if (hstart) begin
                sel <= ~sel;
            end
            obj_pxl <= mem[~sel][hdump];
        end
    end

    always_ff @(posedge clk) begin
        // Earlier objects in the table keep their pixels
        if (we && mem[sel][wr_x].pix == 4'd0) begin
            mem[sel][wr_x] <= wr_pxl;
        end
        mem[~sel][hdump] <= '0;  // Emptied as the beam passes
    end

endmodule

// ==== rtl/obj_video.sv ====
module obj_video #(
    parameter int MODEL = 0
) (
    input  logic               clk,
    input  logic               rst,
    // CPU port
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [9:0]         wb_adr,
    input  logic [15:0]        wb_dat_i,
    output logic [15:0]        wb_dat_o,
    output logic               wb_ack,
    // Sprite ROM
    output logic               rom_cs,
    output logic [19:0]        rom_addr,
    input  logic [15:0]        rom_data,
    input  logic               rom_ok,
    // Video timing
    input  logic               flip,
    input  logic               hstart,
    input  logic [8:0]         vrender,
    input  logic [8:0]         hdump,
    output obj_pkg::lbuf_pxl_t obj_pxl
);

    import obj_pkg::*;

    logic [9:0]  tbl_addr;
    logic [15:0] tbl_dout;
    logic [15:0] tbl_din;
    logic        tbl_we;
    logic        dr_start;
    logic        dr_busy;
    obj_cmd_t    dr_cmd;
    logic        buf_we;
    logic [8:0]  buf_x;
    lbuf_pxl_t   buf_pxl;

    obj_table u_table (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .scan_addr (tbl_addr),
        .scan_dout (tbl_dout),
        .scan_din  (tbl_din),
        .scan_we   (tbl_we)
    );

    obj_scan #(
        .MODEL (MODEL)
    ) u_scan (
        .clk      (clk),
        .rst      (rst),
        .tbl_addr (tbl_addr),
        .tbl_dout (tbl_dout),
        .tbl_din  (tbl_din),
        .tbl_we   (tbl_we),
        .start    (dr_start),
        .busy     (dr_busy),
        .cmd      (dr_cmd),
        .flip     (flip),
        .hstart   (hstart),
        .vrender  (vrender)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .start    (dr_start),
        .cmd      (dr_cmd),
        .busy     (dr_busy),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .buf_we   (buf_we),
        .buf_x    (buf_x),
        .buf_pxl  (buf_pxl)
    );

    obj_linebuf u_linebuf (
        .clk     (clk),
        .rst     (rst),
        .hstart  (hstart),
        .we      (buf_we),
        .wr_x    (buf_x),
        .wr_pxl  (buf_pxl),
        .hdump   (hdump),
        .obj_pxl (obj_pxl)
    );

endmodule

// ==== sim/tb_obj_video.sv ====
`include "obj_defines.svh"

module tb_obj_video;

    import obj_pkg::*;

    localparam int LINE_CYCLES = 600;
    localparam int CLK_PERIOD  = 8;
    localparam int SWEEP_LEN   = 320;  // Visible pixels per line

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [9:0]  wb_adr;
    logic [15:0] wb_dat_i;
    logic [15:0] wb_dat_o;
    logic        wb_ack;
    logic        rom_cs;
    logic [19:0] rom_addr;
    logic [15:0] rom_data;
    logic        rom_ok;
    logic        flip;
    logic        hstart;
    logic [8:0]  vrender;
    logic [8:0]  hdump;
    lbuf_pxl_t   obj_pxl;

    // Picture expected on screen during the current sweep
    lbuf_pxl_t   exp_line [0:SWEEP_LEN-1];
    lbuf_pxl_t   exp_now;
    lbuf_pxl_t   exp_d;
    logic        cmp_on;
    logic        on_d;
    logic [8:0]  cmp_x;
    logic [8:0]  x_d;
    logic [3:0]  exp_bank;
    string       test_name;
    int          errors;

    obj_video #(
        .MODEL (0)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .flip     (flip),
        .hstart   (hstart),
        .vrender  (vrender),
        .hdump    (hdump),
        .obj_pxl  (obj_pxl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(40 * LINE_CYCLES * CLK_PERIOD);
        $display("Run did not finish within 40 lines, %0d errors so far", errors);
        $display("TEST FAIL");
        $finish;
    end

    // Line buffer answers one cycle after hdump
    always @(posedge clk) begin
        on_d  <= cmp_on;
        exp_d <= exp_now;
        x_d   <= cmp_x;
    end

    a_pixel: assert property (
        @(negedge clk) disable iff (rst) on_d |-> obj_pxl == exp_d
    ) else begin
        errors++;
        $display("FAILED %s x=%0d expected %h actual %h", test_name, x_d, exp_d, obj_pxl);
    end

    a_ack_next: assert property (
        @(posedge clk) disable iff (rst) wb_cyc && wb_stb && !wb_ack |=> wb_ack
    ) else begin
        errors++;
        $display("Wishbone ack did not come one cycle after the strobe");
    end

    // Every fetch carries the bank of the drawn object's attribute word
    a_rom_bank: assert property (
        @(posedge clk) disable iff (rst) rom_cs |-> rom_addr[19:16] == exp_bank
    ) else begin
        errors++;
        $display("FAILED %s bank expected %h actual %h", test_name, exp_bank, rom_addr[19:16]);
    end

    // Sprite ROM answers 1 to 4 cycles late with its own address as data
    always begin : rom_model
        int lat;
        @(negedge clk);
        if (rom_cs === 1'b1) begin
            lat = 1 + int'($urandom % 4);
            repeat (lat - 1) @(negedge clk);
            rom_data = rom_addr[15:0];
            rom_ok   = 1'b1;
            @(negedge clk);
            rom_ok   = 1'b0;
        end
    end

    function automatic logic [9:0] tbl_adr(input int obj, input int word);
        return 10'(obj * `OBJ_WORDS + word);
    endfunction

    // Older board attribute layout
    function automatic logic [15:0] attr_word(input logic [5:0] pal, input logic [2:0] bank,
                                              input logic [1:0] prio);
        return {2'b00, pal, 1'b0, bank, 2'b00, prio};
    endfunction

    task automatic wb_write(input logic [9:0] adr, input logic [15:0] dat);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = dat;
        do @(negedge clk); while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [9:0] adr, output logic [15:0] dat);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do @(negedge clk); while (!wb_ack);
        dat    = wb_dat_o;  // Valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] got);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic write_object(input int obj, input logic [7:0] top, input logic [7:0] bottom,
                                input logic [8:0] xpos, input logic [15:0] pitch,
                                input logic [15:0] offset, input logic [15:0] attr);
        wb_write(tbl_adr(obj, 0), {bottom, top});
        wb_write(tbl_adr(obj, 1), {7'd0, xpos});
        wb_write(tbl_adr(obj, 2), pitch);  // Bit 8 doubles as H flip
        wb_write(tbl_adr(obj, 3), offset);
        wb_write(tbl_adr(obj, 4), attr);
    endtask

    task automatic write_end(input int obj);
        wb_write(tbl_adr(obj, 0), {`OBJ_END_MARK, 8'h00});
    endtask

    task automatic clear_expected();
        for (int x = 0; x < SWEEP_LEN; x++) begin
            exp_line[x] = '0;
        end
    endtask

    // Four ROM words from offset with the leftmost nibble first and earlier objects on top
    task automatic paint_object(input logic [8:0] xpos, input logic [15:0] offset,
                                input logic [1:0] prio, input logic [5:0] pal, input bit hflip);
        logic [15:0] word;
        logic [3:0]  nib;
        int          col;
        int          x;
        for (int k = 0; k < `OBJ_WIDTH / 4; k++) begin
            word = offset + 16'(k);
            for (int j = 0; j < 4; j++) begin
                nib = word[15 - 4 * j -: 4];
                col = 4 * k + j;
                x   = hflip ? int'(xpos) + `OBJ_WIDTH - 1 - col : int'(xpos) + col;
                if (nib != 4'd0 && x < SWEEP_LEN && exp_line[x].pix == 4'd0) begin
                    exp_line[x].prio = prio;
                    exp_line[x].pal  = pal;
                    exp_line[x].pix  = nib;
                end
            end
        end
    endtask

    task automatic sweep(input bit check, input bit blank);
        for (int x = 0; x < SWEEP_LEN; x++) begin
            hdump  = 9'(x);
            cmp_x  = 9'(x);
            cmp_on = check;
            if (blank) begin
                exp_now = '0;
            end else begin
                exp_now = exp_line[x];
            end
            @(negedge clk);
        end
        cmp_on = 1'b0;
    endtask

    // One video line is hstart, a sweep of the previous line's pixels and idle cycles
    task automatic run_line(input logic [8:0] vline, input logic vflip, input bit check,
                            input bit reread);
        int used;
        @(negedge clk);
        vrender = vline;
        flip    = vflip;
        hstart  = 1'b1;
        @(negedge clk);
        hstart = 1'b0;
        sweep(check, 1'b0);
        used = 1 + SWEEP_LEN;
        if (reread) begin
            sweep(check, 1'b1);  // First pass emptied every entry
            used = used + SWEEP_LEN;
        end
        if (used < LINE_CYCLES) begin
            repeat (LINE_CYCLES - used) @(negedge clk);
        end
    endtask

    initial begin : main
        logic [9:0]  adr;
        logic [15:0] dat;
        logic [15:0] rd;
        void'($urandom(32'hcfad_d461));
        errors    = 0;
        test_name = "reset";
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_i  = '0;
        rom_data  = '0;
        rom_ok    = 1'b0;
        flip      = 1'b0;
        hstart    = 1'b0;
        vrender   = '0;
        hdump     = '0;
        cmp_on    = 1'b0;
        cmp_x     = '0;
        exp_now   = '0;
        exp_bank  = '0;
        clear_expected();
        repeat (8) @(negedge clk);
        assert (!wb_ack && !rom_cs && obj_pxl == '0 && !UUT.dr_start && !UUT.dr_busy
                && !UUT.tbl_we && !UUT.buf_we)
        else begin
            errors++;
            $display("Outputs were not idle while reset was held");
        end
        rst = 1'b0;

        test_name = "wb_rw";
        for (int i = 0; i < 16; i++) begin
            adr = 10'($urandom);
            dat = 16'($urandom);
            wb_write(adr, dat);
            wb_read(adr, rd);
            check_word(test_name, dat, rd);
        end

        // Two lines with an empty list wipe both buffer halves
        test_name = "flush";
        write_end(0);
        run_line(9'd0, 1'b0, 1'b0, 1'b0);
        run_line(9'd0, 1'b0, 1'b0, 1'b0);

        // Object on lines 10 to 19 with pitch 0x44
        test_name = "visible";
        exp_bank  = 4'h5;
        write_object(0, 8'd10, 8'd20, 9'd50, 16'h0044, 16'h0100, attr_word(6'h2a, 3'h5, 2'h2));
        write_end(1);
        run_line(9'd10, 1'b0, 1'b1, 1'b0);
        paint_object(9'd50, 16'h0100, 2'h2, 6'h2a, 1'b0);
        run_line(9'd11, 1'b0, 1'b1, 1'b0);
        clear_expected();
        paint_object(9'd50, 16'h0144, 2'h2, 6'h2a, 1'b0);
        run_line(9'd12, 1'b0, 1'b1, 1'b0);
        wb_read(tbl_adr(0, `OBJ_SCRATCH_IDX), rd);
        check_word("scratch", 16'h0188, rd);
        clear_expected();
        paint_object(9'd50, 16'h0188, 2'h2, 6'h2a, 1'b0);
        run_line(9'd20, 1'b0, 1'b1, 1'b0);  // Bottom line is outside the zone
        test_name = "outside";
        clear_expected();
        run_line(9'd21, 1'b0, 1'b1, 1'b0);

        // Bad zone and far zone objects with a marker in front of a drawable one
        test_name = "end_mark";
        write_object(0, 8'd40, 8'd30, 9'd20, 16'h0000, 16'h0500, attr_word(6'h01, 3'h0, 2'h0));
        write_object(1, 8'd100, 8'd110, 9'd10, 16'h0000, 16'h0600, attr_word(6'h02, 3'h0, 2'h0));
        write_end(2);
        write_object(3, 8'd35, 8'd40, 9'd100, 16'h0000, 16'h2345, attr_word(6'h11, 3'h1, 2'h1));
        run_line(9'd35, 1'b0, 1'b1, 1'b0);
        run_line(9'd36, 1'b0, 1'b1, 1'b0);
        test_name = "mark_moved";
        exp_bank  = 4'h1;
        wb_write(tbl_adr(2, 0), 16'h0000);
        write_end(4);
        run_line(9'd35, 1'b0, 1'b1, 1'b0);
        paint_object(9'd100, 16'h2345, 2'h1, 6'h11, 1'b0);
        run_line(9'd36, 1'b0, 1'b1, 1'b0);
        run_line(9'd200, 1'b0, 1'b1, 1'b0);  // Zero pitch keeps the offset

        // On a mirrored screen vrender 173 is line 50
        test_name = "hflip";
        exp_bank  = 4'h7;
        clear_expected();
        write_object(0, 8'd50, 8'd60, 9'd200, 16'h0100, 16'h9abc, attr_word(6'h3f, 3'h7, 2'h3));
        write_end(1);
        run_line(9'd173, 1'b1, 1'b1, 1'b0);
        paint_object(9'd200, 16'h9abc, 2'h3, 6'h3f, 1'b1);
        run_line(9'd50, 1'b1, 1'b1, 1'b0);
        clear_expected();
        run_line(9'd60, 1'b0, 1'b1, 1'b0);

        test_name = "overlap";
        exp_bank  = 4'h2;
        write_object(0, 8'd70, 8'd80, 9'd120, 16'h0000, 16'h1020, attr_word(6'h05, 3'h2, 2'h1));
        write_object(1, 8'd70, 8'd80, 9'd128, 16'h0000, 16'h3456, attr_word(6'h31, 3'h2, 2'h2));
        write_end(2);
        run_line(9'd70, 1'b0, 1'b1, 1'b0);
        paint_object(9'd120, 16'h1020, 2'h1, 6'h05, 1'b0);
        paint_object(9'd128, 16'h3456, 2'h2, 6'h31, 1'b0);
        run_line(9'd71, 1'b0, 1'b1, 1'b1);
        run_line(9'd90, 1'b0, 1'b1, 1'b0);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/obj_pkg.sv
rtl/obj_table.sv
rtl/obj_scan.sv
rtl/obj_draw.sv
rtl/obj_linebuf.sv
rtl/obj_video.sv
sim/tb_obj_video.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_obj_video -Mdir obj_dir -f list.f
	./obj_dir/Vtb_obj_video | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
